/* Bender.yml */
package:
  name: spmv_pe

sources:
  - source/pe_cmd_pkg.sv
  - source/pe_mem_pkg.sv
  - source/reg_access_if.sv
  - source/sync_fifo.sv
  - source/pe_register_block.sv
  - source/pe_command_ring.sv
  - source/mem_port.sv
  - source/spmv_pe_top.sv
  - target: test
    files:
      - verification/spmv_pe_tb.sv

/* source/mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_port #(
    parameter int SRC_FIFO_DEPTH = 32,
    parameter int REQ_FIFO_DEPTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mat_ld,
    input  pe_mem_pkg::mem_addr_t mat_ld_addr,
    input  pe_mem_pkg::ld_tag_t   mat_ld_tag,
    output logic                  mat_ld_stall,
    input  logic                  x_ld,
    input  pe_mem_pkg::col_idx_t  x_ld_col,
    output logic                  x_ld_stall,
    input  logic                  y_push,
    input  pe_mem_pkg::mem_data_t y_val,
    output logic                  y_stall,
    output logic                  req_mem_ld,
    output logic                  req_mem_st,
    output pe_mem_pkg::mem_addr_t req_mem_addr,
    output pe_mem_pkg::mem_data_t req_mem_d_or_tag,
    input  logic                  req_mem_stall,
    input  logic                  rsp_mem_push,
    input  logic [2:0]            rsp_mem_tag,
    input  pe_mem_pkg::mem_data_t rsp_mem_q,
    output logic                  rsp_mem_stall,
    output logic                  mat_rsp_push,
    output pe_mem_pkg::ld_tag_t   mat_rsp_tag,
    output pe_mem_pkg::mem_data_t mat_rsp_data,
    output logic                  x_rsp_push,
    output pe_mem_pkg::mem_data_t x_rsp_data,
    input  logic                  mat_rsp_stall,
    output logic                  mem_idle,
    reg_access_if.mem             regs
);
    import pe_mem_pkg::*;

    // slack for producers that stop two cycles after the stall
    localparam int SRC_AF = 4;
    localparam int REQ_AF = 4;

    mat_ld_t   mat_q;
    col_idx_t  col_q;
    mem_data_t val_q;
    mem_req_t  req_next;
    mem_req_t  stage;
    mem_req_t  queue_q;
    logic mat_empty, mat_af;
    logic x_empty, x_af;
    logic y_empty, y_af;
    logic q_empty, q_af;
    logic pop_y, pop_x, pop_mat, q_pop;
    logic s1_st, s1_x, s1_mat;
    mat_ld_t   s1_mat_d;
    col_idx_t  s1_col;
    mem_data_t s1_val;
    logic req_stall_r;
    logic rsp_push_r;
    logic [2:0] rsp_tag_r;
    mem_data_t rsp_q_r;

    sync_fifo #(.payload_t(mat_ld_t), .DEPTH(SRC_FIFO_DEPTH),
                .ALMOST_FULL_COUNT(SRC_AF)) mat_fifo (
        .clk(clk), .rst(rst), .push(mat_ld), .pop(pop_mat), .d({mat_ld_addr, mat_ld_tag}),
        .q(mat_q), .empty(mat_empty), .full(), .almost_full(mat_af));

    sync_fifo #(.payload_t(col_idx_t), .DEPTH(SRC_FIFO_DEPTH),
                .ALMOST_FULL_COUNT(SRC_AF)) x_fifo (
        .clk(clk), .rst(rst), .push(x_ld), .pop(pop_x), .d(x_ld_col),
        .q(col_q), .empty(x_empty), .full(), .almost_full(x_af));

    sync_fifo #(.payload_t(mem_data_t), .DEPTH(SRC_FIFO_DEPTH),
                .ALMOST_FULL_COUNT(SRC_AF)) y_fifo (
        .clk(clk), .rst(rst), .push(y_push), .pop(pop_y), .d(y_val),
        .q(val_q), .empty(y_empty), .full(), .almost_full(y_af));

    // fixed priority with stores first
    assign pop_y   = !q_af && !y_empty;
    assign pop_x   = !q_af && y_empty && !x_empty;
    assign pop_mat = !q_af && y_empty && x_empty && !mat_empty;

    always_ff @(posedge clk) begin
        s1_val   <= val_q;
        s1_col   <= col_q;
        s1_mat_d <= mat_q;
        if (rst) begin
            s1_st  <= 1'b0;
            s1_x   <= 1'b0;
            s1_mat <= 1'b0;
        end else begin
            s1_st  <= pop_y;
            s1_x   <= pop_x;
            s1_mat <= pop_mat;
        end
    end

    // store goes to the y pointer and is dropped once the pointer hits the end
    always_comb begin
        req_next = '0;
        if (s1_st) begin
            req_next.st       = !regs.y_at_end;
            req_next.addr     = regs.y_addr;
            req_next.d_or_tag = s1_val;
        end else if (s1_x) begin
            req_next.ld                  = 1'b1;
            req_next.addr                = regs.x_base + mem_addr_t'(s1_col) * WORD_BYTES;
            req_next.d_or_tag[X_TAG_BIT] = 1'b1;
        end else if (s1_mat) begin
            req_next.ld       = 1'b1;
            req_next.addr     = s1_mat_d.addr;
            req_next.d_or_tag = mem_data_t'({s1_mat_d.tag, 1'b0});
        end
    end

    assign regs.store_issued = s1_st && !regs.y_at_end;

    always_ff @(posedge clk) begin
        stage <= req_next;
        if (rst) begin
            stage.st <= 1'b0;
            stage.ld <= 1'b0;
        end
    end

    sync_fifo #(.payload_t(mem_req_t), .DEPTH(REQ_FIFO_DEPTH),
                .ALMOST_FULL_COUNT(REQ_AF)) req_fifo (
        .clk(clk), .rst(rst), .push(stage.st || stage.ld), .pop(q_pop), .d(stage),
        .q(queue_q), .empty(q_empty), .full(), .almost_full(q_af));

    assign q_pop    = !q_empty && !req_stall_r;
    assign mem_idle = q_empty;

    always_ff @(posedge clk) begin
        req_mem_addr     <= queue_q.addr;
        req_mem_d_or_tag <= queue_q.d_or_tag;
        if (rst) begin
            req_stall_r <= 1'b0;
            req_mem_ld  <= 1'b0;
            req_mem_st  <= 1'b0;
        end else begin
            req_stall_r <= req_mem_stall;
            req_mem_ld  <= q_pop && queue_q.ld;
            req_mem_st  <= q_pop && queue_q.st;
        end
    end

    // registered stall levels and response stage
    always_ff @(posedge clk) begin
        rsp_tag_r <= rsp_mem_tag;
        rsp_q_r   <= rsp_mem_q;
        if (rst) begin
            mat_ld_stall  <= 1'b0;
            x_ld_stall    <= 1'b0;
            y_stall       <= 1'b0;
            rsp_mem_stall <= 1'b0;
            rsp_push_r    <= 1'b0;
        end else begin
            mat_ld_stall  <= mat_af;
            x_ld_stall    <= x_af;
            y_stall       <= y_af;
            rsp_mem_stall <= mat_rsp_stall;
            rsp_push_r    <= rsp_mem_push;
        end
    end

    assign x_rsp_push   = rsp_push_r && rsp_tag_r[X_TAG_BIT];
    assign x_rsp_data   = rsp_q_r;
    assign mat_rsp_push = rsp_push_r && !rsp_tag_r[X_TAG_BIT];
    assign mat_rsp_tag  = rsp_tag_r[2:1];
    assign mat_rsp_data = rsp_q_r;
endmodule

`default_nettype wire

/* source/pe_cmd_pkg.sv */
`default_nettype none

package pe_cmd_pkg;

    // ring opcodes, low nibble of every command word
    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_RST    = 4'd1,
        OP_STEADY = 4'd2,
        OP_LD     = 4'd3,
        OP_READ   = 4'd4,
        OP_RETURN = 4'd5
    } opcode_e;

    // msb set means broadcast to all elements
    typedef logic [7:0]  pe_id_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [47:0] reg_val_t;

    // value | idx | pe | opcode, msb first
    typedef struct packed {
        reg_val_t value;
        reg_idx_t idx;
        pe_id_t   pe;
        opcode_e  opcode;
    } cmd_word_t;

    localparam reg_idx_t REG_Y_ADDR = 4'd0;
    localparam reg_idx_t REG_Y_END  = 4'd1;
    localparam reg_idx_t REG_X_BASE = 4'd2;

    // reads at or above this index get no return word
    localparam int NUM_REGS = 3;

endpackage

`default_nettype wire

/* source/pe_command_ring.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_command_ring #(
    parameter pe_cmd_pkg::pe_id_t PE_ID = '0,
    parameter int STEADY_IDLE_CYCLES = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  pe_cmd_pkg::cmd_word_t op_in,
    output pe_cmd_pkg::cmd_word_t op_out,
    input  logic                  busy_in,
    output logic                  busy_out,
    input  logic                  mem_idle,
    output logic                  pe_rst,
    reg_access_if.cmd             regs
);
    import pe_cmd_pkg::*;

    localparam int CNT_W = $clog2(STEADY_IDLE_CYCLES + 1);

    typedef enum logic {ST_IDLE, ST_STEADY} state_e;

    cmd_word_t op_in_r;
    cmd_word_t op_r;
    cmd_word_t op_out_r;
    cmd_word_t ret_word;
    logic for_me;
    logic is_rst;
    logic is_steady;
    logic is_read_hit;
    logic rst_pending;
    logic cmd_rst;
    state_e state;
    logic [CNT_W-1:0] idle_cnt;
    logic busy_in_r;
    logic busy_out_r;

    // broadcast or our own address
    assign for_me      = op_r.pe[7] || (op_r.pe == PE_ID);
    assign is_rst      = for_me && (op_r.opcode == OP_RST);
    assign is_steady   = for_me && (op_r.opcode == OP_STEADY);
    assign is_read_hit = for_me && (op_r.opcode == OP_READ) && regs.rd_hit;

    assign regs.wr_en   = for_me && (op_r.opcode == OP_LD);
    assign regs.wr_idx  = op_r.idx;
    assign regs.wr_data = op_r.value;
    assign regs.rd_idx  = op_r.idx;

    always_comb begin
        ret_word.value  = regs.rd_data;
        ret_word.idx    = op_r.idx;
        ret_word.pe     = PE_ID;
        ret_word.opcode = OP_RETURN;
    end

    // two-stage ring, a return word takes the forwarded slot
    always_ff @(posedge clk) begin
        if (rst) begin
            op_in_r  <= '0;
            op_r     <= '0;
            op_out_r <= '0;
        end else begin
            op_in_r  <= op_in;
            op_r     <= op_in_r;
            op_out_r <= is_read_hit ? ret_word : op_in_r;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rst_pending <= 1'b0;
            cmd_rst     <= 1'b0;
        end else begin
            rst_pending <= is_rst;
            cmd_rst     <= rst_pending;
        end
    end

    assign pe_rst = rst || cmd_rst;

    // steady ends once idle for the full count
    always_ff @(posedge clk) begin
        if (pe_rst) begin
            state    <= ST_IDLE;
            idle_cnt <= '0;
        end else if (is_steady) begin
            state    <= ST_STEADY;
            idle_cnt <= '0;
        end else if (state == ST_STEADY) begin
            if (!(regs.y_at_end && mem_idle)) begin
                idle_cnt <= '0;
            end else if (idle_cnt == CNT_W'(STEADY_IDLE_CYCLES - 1)) begin
                state    <= ST_IDLE;
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_in_r  <= 1'b0;
            busy_out_r <= 1'b0;
        end else begin
            busy_in_r  <= busy_in;
            busy_out_r <= (state == ST_STEADY) || busy_in_r;
        end
    end

    assign op_out   = op_out_r;
    assign busy_out = busy_out_r;
endmodule

`default_nettype wire

/* source/pe_mem_pkg.sv */
`default_nettype none

package pe_mem_pkg;

    typedef logic [47:0] mem_addr_t;
    typedef logic [63:0] mem_data_t;
    typedef logic [1:0]  ld_tag_t;
    typedef logic [31:0] col_idx_t;

    // matrix stream load, address plus stream tag
    typedef struct packed {
        mem_addr_t addr;
        ld_tag_t   tag;
    } mat_ld_t;

    // one entry of the memory request queue
    typedef struct packed {
        mem_data_t d_or_tag;
        mem_addr_t addr;
        logic      st;
        logic      ld;
    } mem_req_t;

    // x and y vectors hold 64-bit words
    localparam int WORD_BYTES = 8;

    // response tag bit set for x vector loads
    localparam int X_TAG_BIT = 0;

endpackage

`default_nettype wire

/* source/pe_register_block.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_register_block (
    input logic       clk,
    input logic       rst,
    reg_access_if.regs regs
);
    import pe_cmd_pkg::*;
    import pe_mem_pkg::*;

    reg_val_t y_addr;
    reg_val_t y_end;
    reg_val_t x_base;

    always_ff @(posedge clk) begin
        if (rst) begin
            y_addr <= '0;
            y_end  <= '0;
            x_base <= '0;
        end else begin
            // each issued store moves the write pointer one word on
            if (regs.store_issued) begin
                y_addr <= y_addr + reg_val_t'(WORD_BYTES);
            end
            // ring writes come last so they win
            if (regs.wr_en) begin
                case (regs.wr_idx)
                    REG_Y_ADDR: y_addr <= regs.wr_data;
                    REG_Y_END:  y_end  <= regs.wr_data;
                    REG_X_BASE: x_base <= regs.wr_data;
                    default: ;
                endcase
            end
        end
    end

    // combinational read for the ring
    always_comb begin
        regs.rd_hit = (regs.rd_idx < reg_idx_t'(NUM_REGS));
        case (regs.rd_idx)
            REG_Y_ADDR: regs.rd_data = y_addr;
            REG_Y_END:  regs.rd_data = y_end;
            REG_X_BASE: regs.rd_data = x_base;
            default:    regs.rd_data = '0;
        endcase
    end

    assign regs.y_addr   = mem_addr_t'(y_addr);
    assign regs.x_base   = mem_addr_t'(x_base);
    assign regs.y_at_end = (y_addr == y_end);
endmodule

`default_nettype wire

/* source/reg_access_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if;
    import pe_cmd_pkg::*;
    import pe_mem_pkg::*;

    // ring side write and read port
    logic      wr_en;
    reg_idx_t  wr_idx;
    reg_val_t  wr_data;
    reg_idx_t  rd_idx;
    reg_val_t  rd_data;
    logic      rd_hit;

    // memory side view of the vector registers
    mem_addr_t y_addr;
    mem_addr_t x_base;
    logic      y_at_end;
    logic      store_issued;

    modport cmd  (output wr_en, wr_idx, wr_data, rd_idx, input rd_data, rd_hit, y_at_end);
    modport mem  (input y_addr, x_base, y_at_end, output store_issued);
    modport regs (input wr_en, wr_idx, wr_data, rd_idx, store_issued,
                  output rd_data, rd_hit, y_addr, x_base, y_at_end);
endinterface

`default_nettype wire

/* source/spmv_pe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spmv_pe_top #(
    parameter pe_cmd_pkg::pe_id_t PE_ID = '0,
    parameter int STEADY_IDLE_CYCLES = 32,
    parameter int SRC_FIFO_DEPTH = 32,
    parameter int REQ_FIFO_DEPTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  pe_cmd_pkg::cmd_word_t op_in,
    output pe_cmd_pkg::cmd_word_t op_out,
    input  logic                  busy_in,
    output logic                  busy_out,
    input  logic                  mat_ld,
    input  pe_mem_pkg::mem_addr_t mat_ld_addr,
    input  pe_mem_pkg::ld_tag_t   mat_ld_tag,
    output logic                  mat_ld_stall,
    input  logic                  x_ld,
    input  pe_mem_pkg::col_idx_t  x_ld_col,
    output logic                  x_ld_stall,
    input  logic                  y_push,
    input  pe_mem_pkg::mem_data_t y_val,
    output logic                  y_stall,
    output logic                  req_mem_ld,
    output logic                  req_mem_st,
    output pe_mem_pkg::mem_addr_t req_mem_addr,
    output pe_mem_pkg::mem_data_t req_mem_d_or_tag,
    input  logic                  req_mem_stall,
    input  logic                  rsp_mem_push,
    input  logic [2:0]            rsp_mem_tag,
    input  pe_mem_pkg::mem_data_t rsp_mem_q,
    output logic                  rsp_mem_stall,
    output logic                  mat_rsp_push,
    output pe_mem_pkg::ld_tag_t   mat_rsp_tag,
    output pe_mem_pkg::mem_data_t mat_rsp_data,
    output logic                  x_rsp_push,
    output pe_mem_pkg::mem_data_t x_rsp_data,
    input  logic                  mat_rsp_stall
);
    logic pe_rst;
    logic mem_idle;

    reg_access_if regs_if ();

    pe_command_ring #(.PE_ID(PE_ID), .STEADY_IDLE_CYCLES(STEADY_IDLE_CYCLES)) u_ring (
        .clk(clk), .rst(rst), .op_in(op_in), .op_out(op_out), .busy_in(busy_in),
        .busy_out(busy_out), .mem_idle(mem_idle), .pe_rst(pe_rst), .regs(regs_if.cmd));

    // ring reset covers command resets as well as rst
    pe_register_block u_regs (.clk(clk), .rst(pe_rst), .regs(regs_if.regs));

    mem_port #(.SRC_FIFO_DEPTH(SRC_FIFO_DEPTH), .REQ_FIFO_DEPTH(REQ_FIFO_DEPTH)) u_mem (
        .clk(clk), .rst(pe_rst),
        .mat_ld(mat_ld), .mat_ld_addr(mat_ld_addr), .mat_ld_tag(mat_ld_tag),
        .mat_ld_stall(mat_ld_stall),
        .x_ld(x_ld), .x_ld_col(x_ld_col), .x_ld_stall(x_ld_stall),
        .y_push(y_push), .y_val(y_val), .y_stall(y_stall),
        .req_mem_ld(req_mem_ld), .req_mem_st(req_mem_st), .req_mem_addr(req_mem_addr),
        .req_mem_d_or_tag(req_mem_d_or_tag), .req_mem_stall(req_mem_stall),
        .rsp_mem_push(rsp_mem_push), .rsp_mem_tag(rsp_mem_tag), .rsp_mem_q(rsp_mem_q),
        .rsp_mem_stall(rsp_mem_stall),
        .mat_rsp_push(mat_rsp_push), .mat_rsp_tag(mat_rsp_tag), .mat_rsp_data(mat_rsp_data),
        .x_rsp_push(x_rsp_push), .x_rsp_data(x_rsp_data), .mat_rsp_stall(mat_rsp_stall),
        .mem_idle(mem_idle), .regs(regs_if.mem));
endmodule

`default_nettype wire

/* source/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 16,
    parameter int ALMOST_FULL_COUNT = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  logic     pop,
    input  payload_t d,
    output payload_t q,
    output logic     empty,
    output logic     full,
    output logic     almost_full
);
    // depth is a power of two so the pointers wrap by themselves
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    // head entry, valid whenever not empty
    assign q = mem[rd_ptr];

    assign empty       = (count == '0);
    assign full        = (count == CW'(DEPTH));
    assign almost_full = ((CW'(DEPTH) - count) <= CW'(ALMOST_FULL_COUNT));
endmodule

`default_nettype wire

/* tb.f */
source/pe_cmd_pkg.sv
source/pe_mem_pkg.sv
source/reg_access_if.sv
source/sync_fifo.sv
source/pe_register_block.sv
source/pe_command_ring.sv
source/mem_port.sv
source/spmv_pe_top.sv
verification/spmv_pe_tb.sv

/* verification/spmv_pe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module spmv_pe_tb;
    import pe_cmd_pkg::*;
    import pe_mem_pkg::*;

    localparam pe_id_t PE_ID = 8'h03;
    localparam pe_id_t OTHER_PE = 8'h05;
    localparam int STEADY_IDLE = 32;
    localparam int CLK_PERIOD = 100;
    // rough sum of the test lengths in cycles
    localparam int TEST_CYCLES = 300;
    localparam int MARGIN_CYCLES = 200;

    logic clk;
    logic rst;
    cmd_word_t op_in;
    cmd_word_t op_out;
    logic busy_in, busy_out;
    logic mat_ld, mat_ld_stall;
    mem_addr_t mat_ld_addr;
    ld_tag_t mat_ld_tag;
    logic x_ld, x_ld_stall;
    col_idx_t x_ld_col;
    logic y_push, y_stall;
    mem_data_t y_val;
    logic req_mem_ld, req_mem_st, req_mem_stall;
    mem_addr_t req_mem_addr;
    mem_data_t req_mem_d_or_tag;
    logic rsp_mem_push, rsp_mem_stall;
    logic [2:0] rsp_mem_tag;
    mem_data_t rsp_mem_q;
    logic mat_rsp_push, x_rsp_push, mat_rsp_stall;
    ld_tag_t mat_rsp_tag;
    mem_data_t mat_rsp_data;
    mem_data_t x_rsp_data;

    logic [31:0] rng_state = 32'haefbb8bd;
    mem_req_t got_q[$];
    mem_req_t exp_q[$];

    spmv_pe_top #(
        .PE_ID(PE_ID),
        .STEADY_IDLE_CYCLES(STEADY_IDLE),
        .SRC_FIFO_DEPTH(32),
        .REQ_FIFO_DEPTH(32)
    ) i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rand32();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic mem_data_t rand64();
        mem_data_t v;
        v[63:32] = rand32();
        v[31:0] = rand32();
        return v;
    endfunction

    // word aligned byte address
    function automatic mem_addr_t rand_word_addr();
        mem_addr_t a;
        a = mem_addr_t'(rand64());
        a[2:0] = '0;
        return a;
    endfunction

    function automatic cmd_word_t make_cmd(opcode_e op, pe_id_t pe, reg_idx_t idx, reg_val_t val);
        cmd_word_t w;
        w.value = val;
        w.idx = idx;
        w.pe = pe;
        w.opcode = op;
        return w;
    endfunction

    function automatic mem_req_t make_req(mem_data_t d, mem_addr_t a, logic st, logic ld);
        mem_req_t r;
        r.d_or_tag = d;
        r.addr = a;
        r.st = st;
        r.ld = ld;
        return r;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic check_cmd(string name, cmd_word_t got, cmd_word_t exp);
        if (got !== exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic check_data(string name, mem_data_t got, mem_data_t exp);
        if (got !== exp) fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic check_req(mem_req_t got, mem_req_t exp);
        if (got.ld !== exp.ld) fail_run($sformatf("** Error: req_mem_ld = %h, expected %h",
            got.ld, exp.ld));
        if (got.st !== exp.st) fail_run($sformatf("** Error: req_mem_st = %h, expected %h",
            got.st, exp.st));
        if (got.addr !== exp.addr) fail_run($sformatf("** Error: req_mem_addr = %h, expected %h",
            got.addr, exp.addr));
        // loads only use the low three tag bits
        if (exp.st && got.d_or_tag !== exp.d_or_tag)
            fail_run($sformatf("** Error: req_mem_d_or_tag = %h, expected %h",
                got.d_or_tag, exp.d_or_tag));
        if (exp.ld && got.d_or_tag[2:0] !== exp.d_or_tag[2:0])
            fail_run($sformatf("** Error: req_mem_d_or_tag[2:0] = %h, expected %h",
                got.d_or_tag[2:0], exp.d_or_tag[2:0]));
    endtask

    task automatic check_rsp(string name, mem_data_t got, ld_tag_t got_tag,
                             mem_data_t exp, ld_tag_t exp_tag);
        if (got !== exp) fail_run($sformatf("** Error: %s data = %h, expected %h",
            name, got, exp));
        if (got_tag !== exp_tag) fail_run($sformatf("** Error: %s tag = %h, expected %h",
            name, got_tag, exp_tag));
    endtask

    // all stimulus changes 10 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic memory_model();
        req_mem_stall = 1'b0;
        forever begin
            @(negedge clk);
            if (req_mem_ld || req_mem_st) begin
                got_q.push_back(make_req(req_mem_d_or_tag, req_mem_addr, req_mem_st, req_mem_ld));
            end
        end
    endtask

    task automatic drain_reqs();
        int waited;
        waited = 0;
        while (got_q.size() < exp_q.size()) begin
            tick();
            waited++;
            if (waited > 64) fail_run("timed out waiting for memory requests");
        end
        while (exp_q.size() > 0) begin
            check_req(got_q.pop_front(), exp_q.pop_front());
        end
    endtask

    task automatic send_op(cmd_word_t w);
        op_in = w;
        tick();
        op_in = '0;
    endtask

    task automatic load_reg(reg_idx_t idx, reg_val_t val);
        send_op(make_cmd(OP_LD, PE_ID, idx, val));
    endtask

    // forwarded word after two cycles and return word after three
    task automatic read_reg(reg_idx_t idx, reg_val_t exp, logic hit);
        cmd_word_t w;
        w = make_cmd(OP_READ, PE_ID, idx, '0);
        send_op(w);
        tick();
        check_cmd("op_out", op_out, w);
        tick();
        if (hit) check_cmd("op_out", op_out, make_cmd(OP_RETURN, PE_ID, idx, exp));
        else check_cmd("op_out", op_out, '0);
    endtask

    task automatic reset_and_forward();
        cmd_word_t w;
        check_bit("req_mem_ld", req_mem_ld, 1'b0);
        check_bit("req_mem_st", req_mem_st, 1'b0);
        check_bit("busy_out", busy_out, 1'b0);
        check_bit("mat_rsp_push", mat_rsp_push, 1'b0);
        check_bit("x_rsp_push", x_rsp_push, 1'b0);
        check_bit("mat_ld_stall", mat_ld_stall, 1'b0);
        check_bit("x_ld_stall", x_ld_stall, 1'b0);
        check_bit("y_stall", y_stall, 1'b0);
        check_bit("rsp_mem_stall", rsp_mem_stall, 1'b0);
        check_cmd("op_out", op_out, '0);
        w = make_cmd(OP_LD, OTHER_PE, REG_Y_END, reg_val_t'(rand64()));
        send_op(w);
        tick();
        check_cmd("op_out", op_out, w);
    endtask

    task automatic load_and_read();
        reg_val_t vals[NUM_REGS];
        for (int i = 0; i < NUM_REGS; i++) begin
            vals[i] = reg_val_t'(rand64());
            load_reg(reg_idx_t'(i), vals[i]);
        end
        for (int i = 0; i < NUM_REGS; i++) read_reg(reg_idx_t'(i), vals[i], 1'b1);
        read_reg(4'd3, '0, 1'b0);
        // broadcast reset clears every register
        send_op(make_cmd(OP_RST, 8'h80, '0, '0));
        repeat (4) tick();
        for (int i = 0; i < NUM_REGS; i++) read_reg(reg_idx_t'(i), '0, 1'b1);
    endtask

    task automatic matrix_loads();
        mem_addr_t a;
        ld_tag_t t;
        for (int i = 0; i < 8; i++) begin
            a = mem_addr_t'(rand64());
            t = ld_tag_t'(rand32());
            mat_ld = 1'b1;
            mat_ld_addr = a;
            mat_ld_tag = t;
            exp_q.push_back(make_req(mem_data_t'(t) << 1, a, 1'b0, 1'b1));
            tick();
        end
        mat_ld = 1'b0;
        drain_reqs();
    endtask

    task automatic x_loads_and_priority();
        mem_addr_t xb;
        mem_addr_t a;
        mem_addr_t ma;
        col_idx_t col;
        mem_data_t v;
        ld_tag_t t;
        xb = mem_addr_t'(rand64());
        load_reg(REG_X_BASE, reg_val_t'(xb));
        repeat (2) tick();
        for (int i = 0; i < 3; i++) begin
            col = rand32();
            x_ld = 1'b1;
            x_ld_col = col;
            exp_q.push_back(make_req(64'd1, xb + (mem_addr_t'(col) << 3), 1'b0, 1'b1));
            tick();
        end
        x_ld = 1'b0;
        drain_reqs();
        // room for exactly one store
        a = rand_word_addr();
        load_reg(REG_Y_ADDR, reg_val_t'(a));
        load_reg(REG_Y_END, reg_val_t'(a + 48'd8));
        repeat (3) tick();
        v = rand64();
        col = rand32();
        ma = mem_addr_t'(rand64());
        t = ld_tag_t'(rand32());
        y_push = 1'b1;
        y_val = v;
        x_ld = 1'b1;
        x_ld_col = col;
        mat_ld = 1'b1;
        mat_ld_addr = ma;
        mat_ld_tag = t;
        tick();
        y_push = 1'b0;
        x_ld = 1'b0;
        mat_ld = 1'b0;
        exp_q.push_back(make_req(v, a, 1'b1, 1'b0));
        exp_q.push_back(make_req(64'd1, xb + (mem_addr_t'(col) << 3), 1'b0, 1'b1));
        exp_q.push_back(make_req(mem_data_t'(t) << 1, ma, 1'b0, 1'b1));
        drain_reqs();
    endtask

    task automatic stores();
        mem_addr_t a;
        mem_data_t v;
        a = rand_word_addr();
        load_reg(REG_Y_ADDR, reg_val_t'(a));
        load_reg(REG_Y_END, reg_val_t'(a + 48'd24));
        repeat (3) tick();
        for (int i = 0; i < 5; i++) begin
            v = rand64();
            y_push = 1'b1;
            y_val = v;
            if (i < 3) exp_q.push_back(make_req(v, a + mem_addr_t'(8 * i), 1'b1, 1'b0));
            tick();
        end
        y_push = 1'b0;
        drain_reqs();
        repeat (20) tick();
        if (got_q.size() != 0) fail_run("store request issued past the end of the y vector");
        read_reg(REG_Y_ADDR, reg_val_t'(a + 48'd24), 1'b1);
    endtask

    task automatic responses_and_busy();
        mem_data_t d;
        int waited;
        for (int t = 0; t < 8; t++) begin
            d = rand64();
            rsp_mem_push = 1'b1;
            rsp_mem_tag = 3'(t);
            rsp_mem_q = d;
            tick();
            rsp_mem_push = 1'b0;
            check_bit("x_rsp_push", x_rsp_push, t[0]);
            check_bit("mat_rsp_push", mat_rsp_push, !t[0]);
            if (t[0]) check_data("x_rsp_data", x_rsp_data, d);
            else check_rsp("mat_rsp", mat_rsp_data, mat_rsp_tag, d, ld_tag_t'(t >> 1));
        end
        tick();
        check_bit("x_rsp_push", x_rsp_push, 1'b0);
        check_bit("mat_rsp_push", mat_rsp_push, 1'b0);
        // downstream stall comes back one cycle later
        mat_rsp_stall = 1'b1;
        tick();
        check_bit("rsp_mem_stall", rsp_mem_stall, 1'b1);
        mat_rsp_stall = 1'b0;
        tick();
        check_bit("rsp_mem_stall", rsp_mem_stall, 1'b0);
        busy_in = 1'b1;
        repeat (2) tick();
        check_bit("busy_out", busy_out, 1'b1);
        busy_in = 1'b0;
        repeat (2) tick();
        check_bit("busy_out", busy_out, 1'b0);
        // y pointer sits at its end with the queue empty so idle counting starts at once
        send_op(make_cmd(OP_STEADY, PE_ID, '0, '0));
        repeat (3) tick();
        check_bit("busy_out", busy_out, 1'b1);
        repeat (STEADY_IDLE - 4) begin
            tick();
            check_bit("busy_out", busy_out, 1'b1);
        end
        waited = 0;
        while (busy_out) begin
            tick();
            waited++;
            if (waited > 8) fail_run("busy_out stayed high after the steady idle count ran out");
        end
    endtask

    initial memory_model();

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        fail_run("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        op_in = '0;
        busy_in = 1'b0;
        mat_ld = 1'b0;
        mat_ld_addr = '0;
        mat_ld_tag = '0;
        x_ld = 1'b0;
        x_ld_col = '0;
        y_push = 1'b0;
        y_val = '0;
        rsp_mem_push = 1'b0;
        rsp_mem_tag = '0;
        rsp_mem_q = '0;
        mat_rsp_stall = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        reset_and_forward();
        load_and_read();
        matrix_loads();
        x_loads_and_priority();
        stores();
        responses_and_busy();
        $display("TESTBENCH PASSED");
        $finish;
    end
endmodule

`default_nettype wire
